// File: source/ext_bus_pkg.sv
// --------------------------------------------------------------------------
// External peripheral bus definitions
// Bus widths, the external address window seen by the external master
// and the read data returned when a slave never answers
// --------------------------------------------------------------------------

package ext_bus_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // --------------------------------------------------------------------------
  // External window
  // --------------------------------------------------------------------------

  // Addresses matching this window go to the crossbar, all others
  // go back to the host slave port
  localparam logic [ADDR_W-1:0] EXT_WIN_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] EXT_WIN_MASK = 32'hF000_0000;

  // Returned with err on a response timeout
  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hBADCAB1E;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Index width for a number of items, never below one bit
  function automatic int unsigned idx_width(input int unsigned num);
    int unsigned width;
    width = 1;
    if (num > 1) begin
      width = unsigned'($clog2(num));
    end
    return width;
  endfunction

endpackage

// File: source/ext_addr_decoder.sv
// --------------------------------------------------------------------------
// Address decoder
// Matches an address against base/mask rules and returns the lowest
// matching rule index, or the default index on a miss
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_addr_decoder #(
  parameter int unsigned NUM_RULES = 1,
  localparam int unsigned IDX_W = ext_bus_pkg::idx_width(NUM_RULES)
) (
  input  logic [ext_bus_pkg::ADDR_W-1:0]                addr_i,
  input  logic [NUM_RULES-1:0][ext_bus_pkg::ADDR_W-1:0] base_i,
  input  logic [NUM_RULES-1:0][ext_bus_pkg::ADDR_W-1:0] mask_i,
  input  logic [IDX_W-1:0]                              default_idx_i,
  output logic [IDX_W-1:0]                              idx_o,
  output logic                                          hit_o
);

  // Walk down so the lowest matching rule is the last one written
  always_comb begin
    idx_o = default_idx_i;
    hit_o = 1'b0;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if ((addr_i & mask_i[i]) == (base_i[i] & mask_i[i])) begin
        idx_o = IDX_W'(i);
        hit_o = 1'b1;
      end
    end
  end

endmodule

// File: source/ext_master_demux.sv
// --------------------------------------------------------------------------
// External master demux
// Sends requests inside the external window to the crossbar (port a)
// and all others to the host slave port (port b)
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_master_demux (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Master side
  input  logic                             m_req_i,
  input  logic [ext_bus_pkg::ADDR_W-1:0]   m_addr_i,
  input  logic                             m_we_i,
  input  logic [ext_bus_pkg::BE_W-1:0]     m_be_i,
  input  logic [ext_bus_pkg::DATA_W-1:0]   m_wdata_i,
  output logic                             m_gnt_o,
  output logic                             m_rvalid_o,
  output logic [ext_bus_pkg::DATA_W-1:0]   m_rdata_o,
  output logic                             m_err_o,
  // Port a, towards the crossbar
  output logic                             a_req_o,
  output logic [ext_bus_pkg::ADDR_W-1:0]   a_addr_o,
  output logic                             a_we_o,
  output logic [ext_bus_pkg::BE_W-1:0]     a_be_o,
  output logic [ext_bus_pkg::DATA_W-1:0]   a_wdata_o,
  input  logic                             a_gnt_i,
  input  logic                             a_rvalid_i,
  input  logic [ext_bus_pkg::DATA_W-1:0]   a_rdata_i,
  input  logic                             a_err_i,
  // Port b, towards the host slave port
  output logic                             b_req_o,
  output logic [ext_bus_pkg::ADDR_W-1:0]   b_addr_o,
  output logic                             b_we_o,
  output logic [ext_bus_pkg::BE_W-1:0]     b_be_o,
  output logic [ext_bus_pkg::DATA_W-1:0]   b_wdata_o,
  input  logic                             b_gnt_i,
  input  logic                             b_rvalid_i,
  input  logic [ext_bus_pkg::DATA_W-1:0]   b_rdata_i
);

  import ext_bus_pkg::*;

  logic sel_b;
  logic resp_b_q;

  // Rule 0 is the external window, a miss defaults to port b
  ext_addr_decoder #(
    .NUM_RULES(1)
  ) u_decoder (
    .addr_i       (m_addr_i),
    .base_i       (EXT_WIN_BASE),
    .mask_i       (EXT_WIN_MASK),
    .default_idx_i(1'b1),
    .idx_o        (sel_b),
    .hit_o        ()
  );

  assign a_req_o   = m_req_i & ~sel_b;
  assign b_req_o   = m_req_i & sel_b;
  assign a_addr_o  = m_addr_i;
  assign a_we_o    = m_we_i;
  assign a_be_o    = m_be_i;
  assign a_wdata_o = m_wdata_i;
  assign b_addr_o  = m_addr_i;
  assign b_we_o    = m_we_i;
  assign b_be_o    = m_be_i;
  assign b_wdata_o = m_wdata_i;

  // Only a pending request sees the target's grant
  assign m_gnt_o = m_req_i & (sel_b ? b_gnt_i : a_gnt_i);

  // Remember which side owns the pending response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_b_q <= 1'b0;
    end else if (m_req_i && m_gnt_o) begin
      resp_b_q <= sel_b;
    end
  end

  assign m_rvalid_o = resp_b_q ? b_rvalid_i : a_rvalid_i;
  assign m_rdata_o  = resp_b_q ? b_rdata_i : a_rdata_i;
  // The host slave port never reports errors
  assign m_err_o    = ~resp_b_q & a_err_i;

endmodule

// File: source/ext_resp_timer.sv
// --------------------------------------------------------------------------
// Response timer
// Counts the cycles spent waiting for a response and flags the cycle
// in which the wait reaches the timeout
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_resp_timer #(
  parameter int unsigned TIMEOUT_CYCLES = 8
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic run_i,
  output logic expired_o
);

  import ext_bus_pkg::*;

  localparam int unsigned CNT_W = idx_width(TIMEOUT_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // Loaded with one at the grant edge, so cycle k of the wait sees k
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(1);
    end else if (run_i && (cnt_q != CNT_W'(TIMEOUT_CYCLES))) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign expired_o = run_i && (cnt_q == CNT_W'(TIMEOUT_CYCLES));

endmodule

// File: source/ext_arbiter_fsm.sv
// --------------------------------------------------------------------------
// Round-robin arbiter FSM
// Grants one master at a time and holds the bus until its response
// arrives or the response timer expires
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_arbiter_fsm #(
  parameter int unsigned NUM_MASTERS = 2,
  localparam int unsigned IDX_W = ext_bus_pkg::idx_width(NUM_MASTERS)
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [NUM_MASTERS-1:0] req_i,
  input  logic                   slave_gnt_i,
  input  logic                   slave_rvalid_i,
  input  logic                   expired_i,
  output logic [IDX_W-1:0]       winner_o,
  output logic                   sel_valid_o,
  output logic                   granted_o,
  output logic                   waiting_o,
  output logic                   timeout_resp_o
);

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e           state_q;
  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] winner_q;
  logic [IDX_W-1:0] pick_idx;

  // First requester at or after the pointer, lowest offset wins
  always_comb begin
    pick_idx = '0;
    for (int k = NUM_MASTERS - 1; k >= 0; k--) begin
      if (req_i[(int'(rr_q) + k) % NUM_MASTERS]) begin
        pick_idx = IDX_W'((int'(rr_q) + k) % NUM_MASTERS);
      end
    end
  end

  assign sel_valid_o    = (state_q == IDLE) && (|req_i);
  assign granted_o      = sel_valid_o && slave_gnt_i;
  assign waiting_o      = (state_q == WAIT);
  assign winner_o       = waiting_o ? winner_q : pick_idx;
  // A real response in the last cycle still wins over the timeout
  assign timeout_resp_o = waiting_o && expired_i && !slave_rvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      rr_q     <= '0;
      winner_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (granted_o) begin
            state_q  <= WAIT;
            winner_q <= pick_idx;
            rr_q     <= (pick_idx == IDX_W'(NUM_MASTERS - 1)) ? '0 : pick_idx + 1'b1;
          end
        end
        WAIT: begin
          if (slave_rvalid_i || expired_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// File: source/ext_xbar.sv
// --------------------------------------------------------------------------
// Shared-path crossbar
// One transaction at a time from many masters to many slaves, with an
// address map given at run time and an error response on timeout
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_xbar #(
  parameter int unsigned NUM_MASTERS    = 3,
  parameter int unsigned NUM_SLAVES     = 2,
  parameter int unsigned TIMEOUT_CYCLES = 8,
  localparam int unsigned MST_W = ext_bus_pkg::idx_width(NUM_MASTERS),
  localparam int unsigned SLV_W = ext_bus_pkg::idx_width(NUM_SLAVES)
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Address map
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0]  slave_base_i,
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0]  slave_mask_i,
  input  logic [SLV_W-1:0]                                default_idx_i,
  // Master ports
  input  logic [NUM_MASTERS-1:0]                          master_req_i,
  input  logic [NUM_MASTERS-1:0][ext_bus_pkg::ADDR_W-1:0] master_addr_i,
  input  logic [NUM_MASTERS-1:0]                          master_we_i,
  input  logic [NUM_MASTERS-1:0][ext_bus_pkg::BE_W-1:0]   master_be_i,
  input  logic [NUM_MASTERS-1:0][ext_bus_pkg::DATA_W-1:0] master_wdata_i,
  output logic [NUM_MASTERS-1:0]                          master_gnt_o,
  output logic [NUM_MASTERS-1:0]                          master_rvalid_o,
  output logic [NUM_MASTERS-1:0][ext_bus_pkg::DATA_W-1:0] master_rdata_o,
  output logic [NUM_MASTERS-1:0]                          master_err_o,
  // Slave ports
  output logic [NUM_SLAVES-1:0]                           slave_req_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0]  slave_addr_o,
  output logic [NUM_SLAVES-1:0]                           slave_we_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::BE_W-1:0]    slave_be_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::DATA_W-1:0]  slave_wdata_o,
  input  logic [NUM_SLAVES-1:0]                           slave_gnt_i,
  input  logic [NUM_SLAVES-1:0]                           slave_rvalid_i,
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::DATA_W-1:0]  slave_rdata_i,
  input  logic [NUM_SLAVES-1:0]                           slave_err_i
);

  import ext_bus_pkg::*;

  logic [MST_W-1:0]  winner;
  logic [SLV_W-1:0]  dec_idx;
  logic [SLV_W-1:0]  slv_q;
  logic              sel_valid;
  logic              sel_gnt;
  logic              granted;
  logic              waiting;
  logic              expired;
  logic              timeout_resp;
  logic              rsp_rvalid;
  logic              resp_valid;
  logic [DATA_W-1:0] resp_rdata;
  logic              resp_err;

  ext_addr_decoder #(
    .NUM_RULES(NUM_SLAVES)
  ) u_decoder (
    .addr_i       (master_addr_i[winner]),
    .base_i       (slave_base_i),
    .mask_i       (slave_mask_i),
    .default_idx_i(default_idx_i),
    .idx_o        (dec_idx),
    .hit_o        ()
  );

  ext_arbiter_fsm #(
    .NUM_MASTERS(NUM_MASTERS)
  ) u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (master_req_i),
    .slave_gnt_i   (sel_gnt),
    .slave_rvalid_i(rsp_rvalid),
    .expired_i     (expired),
    .winner_o      (winner),
    .sel_valid_o   (sel_valid),
    .granted_o     (granted),
    .waiting_o     (waiting),
    .timeout_resp_o(timeout_resp)
  );

  ext_resp_timer #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_timer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (granted),
    .run_i    (waiting),
    .expired_o(expired)
  );

  assign sel_gnt = sel_valid & slave_gnt_i[dec_idx];

  // Slave owning the pending response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slv_q <= '0;
    end else if (granted) begin
      slv_q <= dec_idx;
    end
  end

  // ------------------------------------------------------------------------
  // Request path
  // ------------------------------------------------------------------------

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : gen_slave
    assign slave_req_o[s]   = sel_valid && (dec_idx == SLV_W'(s));
    assign slave_addr_o[s]  = master_addr_i[winner];
    assign slave_we_o[s]    = master_we_i[winner];
    assign slave_be_o[s]    = master_be_i[winner];
    assign slave_wdata_o[s] = master_wdata_i[winner];
  end

  // ------------------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------------------

  // Late answers outside WAIT are dropped here
  assign rsp_rvalid = waiting & slave_rvalid_i[slv_q];
  assign resp_valid = rsp_rvalid | timeout_resp;
  assign resp_rdata = timeout_resp ? ERR_RDATA : slave_rdata_i[slv_q];
  assign resp_err   = timeout_resp | slave_err_i[slv_q];

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_master
    assign master_gnt_o[m]    = sel_gnt && (winner == MST_W'(m));
    assign master_rvalid_o[m] = resp_valid && (winner == MST_W'(m));
    assign master_rdata_o[m]  = resp_rdata;
    assign master_err_o[m]    = master_rvalid_o[m] & resp_err;
  end

endmodule

// File: source/ext_bus.sv
// --------------------------------------------------------------------------
// External peripheral bus
// Host masters and the demuxed external master share one crossbar to
// the external slaves
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ext_bus #(
  parameter int unsigned NUM_HOST       = 2,
  parameter int unsigned NUM_SLAVES     = 2,
  parameter int unsigned TIMEOUT_CYCLES = 8,
  localparam int unsigned SLV_W = ext_bus_pkg::idx_width(NUM_SLAVES)
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Address map
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0] slave_base_i,
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0] slave_mask_i,
  input  logic [SLV_W-1:0]                               default_idx_i,
  // Host masters
  input  logic [NUM_HOST-1:0]                            host_req_i,
  input  logic [NUM_HOST-1:0][ext_bus_pkg::ADDR_W-1:0]   host_addr_i,
  input  logic [NUM_HOST-1:0]                            host_we_i,
  input  logic [NUM_HOST-1:0][ext_bus_pkg::BE_W-1:0]     host_be_i,
  input  logic [NUM_HOST-1:0][ext_bus_pkg::DATA_W-1:0]   host_wdata_i,
  output logic [NUM_HOST-1:0]                            host_gnt_o,
  output logic [NUM_HOST-1:0]                            host_rvalid_o,
  output logic [NUM_HOST-1:0][ext_bus_pkg::DATA_W-1:0]   host_rdata_o,
  output logic [NUM_HOST-1:0]                            host_err_o,
  // External master
  input  logic                                           ext_m_req_i,
  input  logic [ext_bus_pkg::ADDR_W-1:0]                 ext_m_addr_i,
  input  logic                                           ext_m_we_i,
  input  logic [ext_bus_pkg::BE_W-1:0]                   ext_m_be_i,
  input  logic [ext_bus_pkg::DATA_W-1:0]                 ext_m_wdata_i,
  output logic                                           ext_m_gnt_o,
  output logic                                           ext_m_rvalid_o,
  output logic [ext_bus_pkg::DATA_W-1:0]                 ext_m_rdata_o,
  output logic                                           ext_m_err_o,
  // Host slave port
  output logic                                           heep_slave_req_o,
  output logic [ext_bus_pkg::ADDR_W-1:0]                 heep_slave_addr_o,
  output logic                                           heep_slave_we_o,
  output logic [ext_bus_pkg::BE_W-1:0]                   heep_slave_be_o,
  output logic [ext_bus_pkg::DATA_W-1:0]                 heep_slave_wdata_o,
  input  logic                                           heep_slave_gnt_i,
  input  logic                                           heep_slave_rvalid_i,
  input  logic [ext_bus_pkg::DATA_W-1:0]                 heep_slave_rdata_i,
  // External slaves
  output logic [NUM_SLAVES-1:0]                          ext_slave_req_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::ADDR_W-1:0] ext_slave_addr_o,
  output logic [NUM_SLAVES-1:0]                          ext_slave_we_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::BE_W-1:0]   ext_slave_be_o,
  output logic [NUM_SLAVES-1:0][ext_bus_pkg::DATA_W-1:0] ext_slave_wdata_o,
  input  logic [NUM_SLAVES-1:0]                          ext_slave_gnt_i,
  input  logic [NUM_SLAVES-1:0]                          ext_slave_rvalid_i,
  input  logic [NUM_SLAVES-1:0][ext_bus_pkg::DATA_W-1:0] ext_slave_rdata_i,
  input  logic [NUM_SLAVES-1:0]                          ext_slave_err_i
);

  import ext_bus_pkg::*;

  // Demux port a, i.e. the last crossbar master
  logic              dmx_req;
  logic [ADDR_W-1:0] dmx_addr;
  logic              dmx_we;
  logic [BE_W-1:0]   dmx_be;
  logic [DATA_W-1:0] dmx_wdata;

  // Crossbar master side, hosts first
  logic [NUM_HOST:0]             mst_gnt;
  logic [NUM_HOST:0]             mst_rvalid;
  logic [NUM_HOST:0][DATA_W-1:0] mst_rdata;
  logic [NUM_HOST:0]             mst_err;

  ext_master_demux u_demux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .m_req_i   (ext_m_req_i),
    .m_addr_i  (ext_m_addr_i),
    .m_we_i    (ext_m_we_i),
    .m_be_i    (ext_m_be_i),
    .m_wdata_i (ext_m_wdata_i),
    .m_gnt_o   (ext_m_gnt_o),
    .m_rvalid_o(ext_m_rvalid_o),
    .m_rdata_o (ext_m_rdata_o),
    .m_err_o   (ext_m_err_o),
    .a_req_o   (dmx_req),
    .a_addr_o  (dmx_addr),
    .a_we_o    (dmx_we),
    .a_be_o    (dmx_be),
    .a_wdata_o (dmx_wdata),
    .a_gnt_i   (mst_gnt[NUM_HOST]),
    .a_rvalid_i(mst_rvalid[NUM_HOST]),
    .a_rdata_i (mst_rdata[NUM_HOST]),
    .a_err_i   (mst_err[NUM_HOST]),
    .b_req_o   (heep_slave_req_o),
    .b_addr_o  (heep_slave_addr_o),
    .b_we_o    (heep_slave_we_o),
    .b_be_o    (heep_slave_be_o),
    .b_wdata_o (heep_slave_wdata_o),
    .b_gnt_i   (heep_slave_gnt_i),
    .b_rvalid_i(heep_slave_rvalid_i),
    .b_rdata_i (heep_slave_rdata_i)
  );

  ext_xbar #(
    .NUM_MASTERS   (NUM_HOST + 1),
    .NUM_SLAVES    (NUM_SLAVES),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_xbar (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slave_base_i   (slave_base_i),
    .slave_mask_i   (slave_mask_i),
    .default_idx_i  (default_idx_i),
    .master_req_i   ({dmx_req, host_req_i}),
    .master_addr_i  ({dmx_addr, host_addr_i}),
    .master_we_i    ({dmx_we, host_we_i}),
    .master_be_i    ({dmx_be, host_be_i}),
    .master_wdata_i ({dmx_wdata, host_wdata_i}),
    .master_gnt_o   (mst_gnt),
    .master_rvalid_o(mst_rvalid),
    .master_rdata_o (mst_rdata),
    .master_err_o   (mst_err),
    .slave_req_o    (ext_slave_req_o),
    .slave_addr_o   (ext_slave_addr_o),
    .slave_we_o     (ext_slave_we_o),
    .slave_be_o     (ext_slave_be_o),
    .slave_wdata_o  (ext_slave_wdata_o),
    .slave_gnt_i    (ext_slave_gnt_i),
    .slave_rvalid_i (ext_slave_rvalid_i),
    .slave_rdata_i  (ext_slave_rdata_i),
    .slave_err_i    (ext_slave_err_i)
  );

  assign host_gnt_o    = mst_gnt[NUM_HOST-1:0];
  assign host_rvalid_o = mst_rvalid[NUM_HOST-1:0];
  assign host_rdata_o  = mst_rdata[NUM_HOST-1:0];
  assign host_err_o    = mst_err[NUM_HOST-1:0];

endmodule

// File: sim/tb_clock_gen.sv
// --------------------------------------------------------------------------
// Testbench clock and reset
// 40 ns clock, active-low reset held for a few cycles
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_NS    = 20,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: sim/tb_ext_bus.sv
// --------------------------------------------------------------------------
// External bus testbench
// Two host masters and the external master against two external slaves
// and the host slave port, with address map, default and timeout checks
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_ext_bus;

  import ext_bus_pkg::*;

  localparam int NUM_HOST     = 2;
  localparam int NUM_SLAVES   = 2;
  localparam int TIMEOUT      = 8;
  localparam int N_TXN        = 26;
  localparam int WATCH_CYCLES = N_TXN * (TIMEOUT + 8) + 10;
  localparam logic DEF_IDX    = 1'b1;

  // Per-target read key, index 2 is the host slave port
  localparam logic [2:0][31:0] KEY = {32'hC3C3_2222, 32'h0F0F_1111, 32'h5A5A_0000};
  localparam logic [1:0][31:0] BASE = {32'h8000_1000, 32'h8000_0000};
  localparam logic [1:0][31:0] MASK = {32'hFFFF_F000, 32'hFFFF_F000};

  logic clk;
  logic rst_n;

  // Master side, index 2 is the external master
  logic [2:0]       m_req;
  logic [2:0][31:0] m_addr;
  logic [2:0]       m_we;
  logic [2:0][3:0]  m_be;
  logic [2:0][31:0] m_wdata;
  logic [2:0]       m_gnt;
  logic [2:0]       m_rvalid;
  logic [2:0][31:0] m_rdata;
  logic [2:0]       m_err;

  // Slave side, index 2 is the host slave port
  logic [2:0]       s_req;
  logic [2:0][31:0] s_addr;
  logic [2:0]       s_we;
  logic [2:0][3:0]  s_be;
  logic [2:0][31:0] s_wdata;
  logic [2:0]       s_gnt;
  logic [2:0]       s_rvalid = '0;
  logic [2:0][31:0] s_rdata = '0;
  logic [1:0]       s_err;
  logic             stall1;

  int unsigned value_errs;
  int unsigned proto_errs;
  logic [31:0] addr_state;
  logic [31:0] lat_state;

  tb_clock_gen u_clk (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  ext_bus #(
    .NUM_HOST      (NUM_HOST),
    .NUM_SLAVES    (NUM_SLAVES),
    .TIMEOUT_CYCLES(TIMEOUT)
  ) u_dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .slave_base_i       (BASE),
    .slave_mask_i       (MASK),
    .default_idx_i      (DEF_IDX),
    .host_req_i         (m_req[1:0]),
    .host_addr_i        (m_addr[1:0]),
    .host_we_i          (m_we[1:0]),
    .host_be_i          (m_be[1:0]),
    .host_wdata_i       (m_wdata[1:0]),
    .host_gnt_o         (m_gnt[1:0]),
    .host_rvalid_o      (m_rvalid[1:0]),
    .host_rdata_o       (m_rdata[1:0]),
    .host_err_o         (m_err[1:0]),
    .ext_m_req_i        (m_req[2]),
    .ext_m_addr_i       (m_addr[2]),
    .ext_m_we_i         (m_we[2]),
    .ext_m_be_i         (m_be[2]),
    .ext_m_wdata_i      (m_wdata[2]),
    .ext_m_gnt_o        (m_gnt[2]),
    .ext_m_rvalid_o     (m_rvalid[2]),
    .ext_m_rdata_o      (m_rdata[2]),
    .ext_m_err_o        (m_err[2]),
    .heep_slave_req_o   (s_req[2]),
    .heep_slave_addr_o  (s_addr[2]),
    .heep_slave_we_o    (s_we[2]),
    .heep_slave_be_o    (s_be[2]),
    .heep_slave_wdata_o (s_wdata[2]),
    .heep_slave_gnt_i   (s_gnt[2]),
    .heep_slave_rvalid_i(s_rvalid[2]),
    .heep_slave_rdata_i (s_rdata[2]),
    .ext_slave_req_o    (s_req[1:0]),
    .ext_slave_addr_o   (s_addr[1:0]),
    .ext_slave_we_o     (s_we[1:0]),
    .ext_slave_be_o     (s_be[1:0]),
    .ext_slave_wdata_o  (s_wdata[1:0]),
    .ext_slave_gnt_i    (s_gnt[1:0]),
    .ext_slave_rvalid_i (s_rvalid[1:0]),
    .ext_slave_rdata_i  (s_rdata[1:0]),
    .ext_slave_err_i    (s_err)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic in_window(input logic [31:0] a);
    return (a & EXT_WIN_MASK) == (EXT_WIN_BASE & EXT_WIN_MASK);
  endfunction

  // Target 0/1 is an external slave, 2 is the host slave port
  function automatic int route(input int m, input logic [31:0] a);
    int t;
    t = int'(DEF_IDX);
    if (m == 2 && !in_window(a)) begin
      return 2;
    end
    for (int r = 1; r >= 0; r--) begin
      if ((a & MASK[r]) == (BASE[r] & MASK[r])) begin
        t = r;
      end
    end
    return t;
  endfunction

  // --------------------------------------------------------------------------
  // Slave models
  // --------------------------------------------------------------------------

  logic [2:0]       busy;
  int               cnt [3];
  logic [2:0][31:0] held_addr;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= '0;
      s_rvalid <= '0;
      s_rdata  <= '0;
    end else begin
      for (int s = 0; s < 3; s++) begin
        s_rvalid[s] <= 1'b0;
        if (busy[s]) begin
          if (cnt[s] == 0) begin
            s_rvalid[s] <= 1'b1;
            s_rdata[s]  <= held_addr[s] ^ KEY[s];
            busy[s]     <= 1'b0;
          end else begin
            cnt[s] <= cnt[s] - 1;
          end
        end
        if (s_req[s] && s_gnt[s]) begin
          lat_state = xorshift(lat_state);
          // A stalled slave takes the request and never answers
          busy[s]      <= !(s == 1 && stall1);
          cnt[s]       <= int'(lat_state[1:0]) % 3;
          held_addr[s] <= s_addr[s];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Bus ownership monitor
  // --------------------------------------------------------------------------

  logic [2:0] xreq;
  logic [2:0] xgnt;
  logic       ext_xq;
  logic       xbusy;
  int         owner;
  // Masters granted since each master began to wait
  logic [2:0] served [3];

  assign xreq = {m_req[2] & in_window(m_addr[2]), m_req[1:0]};
  assign xgnt = {m_gnt[2] & in_window(m_addr[2]), m_gnt[1:0]};

  always @(negedge clk) begin
    logic [2:0] xrv;
    if (!rst_n) begin
      xbusy  = 1'b0;
      ext_xq = 1'b0;
      served = '{3'b000, 3'b000, 3'b000};
    end else begin
      xrv = {m_rvalid[2] & ext_xq, m_rvalid[1:0]};
      if (xrv != 3'b000) begin
        assert (xbusy && xrv == (3'b001 << owner)) else begin
          $display("Response without a matching grant at %0t", $time);
          proto_errs++;
        end
        xbusy = 1'b0;
      end
      if (m_gnt[2]) begin
        ext_xq = in_window(m_addr[2]);
      end
      for (int m = 0; m < 3; m++) begin
        if (xgnt[m]) begin
          assert (!xbusy) else begin
            $display("Grant to master %0d while the crossbar is busy", m);
            proto_errs++;
          end
          xbusy = 1'b1;
          owner = m;
          served[m] = 3'b000;
          for (int k = 0; k < 3; k++) begin
            if (k != m && xreq[k]) begin
              assert (!served[k][m]) else begin
                $display("Master %0d granted twice while master %0d waits", m, k);
                proto_errs++;
              end
              served[k][m] = 1'b1;
            end
          end
        end
      end
    end
  end

  assert property (@(negedge clk) disable iff (!rst_n) $onehot0(s_req[1:0]))
    else begin
      $display("More than one external slave sees a request");
      proto_errs++;
    end

  assert property (@(negedge clk) disable iff (!rst_n) $onehot0(xgnt))
    else begin
      $display("More than one crossbar grant in one cycle");
      proto_errs++;
    end

  // --------------------------------------------------------------------------
  // Master tasks
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic transfer(input int m, input logic [31:0] addr, input logic we,
                          input logic timeout);
    int          t;
    int          lat;
    logic [31:0] wdata;
    logic [3:0]  be;
    t = route(m, addr);
    wdata = xorshift(addr ^ 32'h1234_5678);
    be = we ? wdata[3:0] | 4'b0001 : 4'hF;
    @(posedge clk);
    m_req[m]   <= 1'b1;
    m_addr[m]  <= addr;
    m_we[m]    <= we;
    m_be[m]    <= be;
    m_wdata[m] <= wdata;
    do @(negedge clk); while (!m_gnt[m]);
    // Address phase seen by the decoded slave
    check_value($sformatf("slave_req[%0d]", t), 32'(s_req[t]), 32'd1);
    check_value($sformatf("slave_addr[%0d]", t), s_addr[t], addr);
    check_value($sformatf("slave_we[%0d]", t), 32'(s_we[t]), 32'(we));
    check_value($sformatf("slave_be[%0d]", t), 32'(s_be[t]), 32'(be));
    if (we) begin
      check_value($sformatf("slave_wdata[%0d]", t), s_wdata[t], wdata);
    end
    @(posedge clk);
    m_req[m] <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!m_rvalid[m]);
    check_value($sformatf("err[%0d]", m), 32'(m_err[m]), 32'(timeout));
    if (timeout) begin
      check_value($sformatf("rdata[%0d]", m), m_rdata[m], ERR_RDATA);
      check_value("timeout latency", 32'(lat), 32'(TIMEOUT));
    end else if (!we) begin
      check_value($sformatf("rdata[%0d]", m), m_rdata[m], addr ^ KEY[t]);
    end
  endtask

  function automatic logic [31:0] rand_offset();
    addr_state = xorshift(addr_state);
    return {20'h0, addr_state[11:2], 2'b00};
  endfunction

  task automatic run_master(input int m, input int n);
    for (int i = 0; i < n; i++) begin
      transfer(m, BASE[(i + m) % 2] + rand_offset(), 1'b0, 1'b0);
    end
  endtask

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("Run stopped by watchdog, transactions did not complete");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    value_errs = 0;
    proto_errs = 0;
    addr_state = 32'h037f8883;
    lat_state  = 32'h037f8883;
    m_req   <= '0;
    m_addr  <= '0;
    m_we    <= '0;
    m_be    <= '0;
    m_wdata <= '0;
    s_gnt   <= 3'b111;
    s_err   <= '0;
    stall1  <= 1'b0;
    @(posedge rst_n);

    // Reads and writes from each host master to each slave
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 2; s++) begin
        transfer(m, BASE[s] + rand_offset(), 1'b0, 1'b0);
        transfer(m, BASE[s] + rand_offset(), 1'b1, 1'b0);
      end
    end

    // External master inside and outside the window
    transfer(2, BASE[0] + rand_offset(), 1'b0, 1'b0);
    transfer(2, BASE[1] + rand_offset(), 1'b0, 1'b0);
    transfer(2, 32'h2000_0000 + rand_offset(), 1'b0, 1'b0);
    transfer(2, 32'h2000_0000 + rand_offset(), 1'b1, 1'b0);

    // Unmapped addresses go to the default slave
    transfer(0, 32'h8000_5000, 1'b0, 1'b0);
    transfer(2, 32'h8000_7004, 1'b0, 1'b0);

    // All three masters at once
    fork
      run_master(0, 3);
      run_master(1, 3);
      run_master(2, 3);
    join

    // Slave 1 never answers
    @(posedge clk);
    stall1 <= 1'b1;
    fork
      transfer(1, 32'h8000_1010, 1'b0, 1'b1);
      transfer(0, BASE[0] + rand_offset(), 1'b0, 1'b0);
    join
    @(posedge clk);
    stall1 <= 1'b0;

    // Bus is served again after the timeout
    transfer(2, BASE[1] + rand_offset(), 1'b0, 1'b0);

    repeat (2) @(posedge clk);
    $display("Checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
source/ext_bus_pkg.sv
source/ext_addr_decoder.sv
source/ext_master_demux.sv
source/ext_resp_timer.sv
source/ext_arbiter_fsm.sv
source/ext_xbar.sv
source/ext_bus.sv
sim/tb_clock_gen.sv
sim/tb_ext_bus.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ext_bus \
		-f files.f -Mdir obj_dir
	./obj_dir/Vtb_ext_bus | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
